// ==== hdl/tuner_pkg.sv ====
package tuner_pkg;

    //////////////////////////////
    // Note and mode encodings
    //////////////////////////////

    localparam int NOTE_COUNT = 12;

    // Ascending semitones, wraps after note_b
    typedef enum logic [3:0] {
        note_c,
        note_db,
        note_d,
        note_eb,
        note_e,
        note_f,
        note_gb,
        note_g,
        note_ab,
        note_a,
        note_bb,
        note_b
    } note_t;

    typedef enum logic [1:0] {
        mode_custom,
        mode_guitar,
        mode_bass,
        mode_uke
    } mode_t;

    //////////////////////////////
    // Pitch
    //////////////////////////////

    // slowClk cycles per half tone period
    typedef logic [19:0] half_period_t;

    // Counts at 100 MHz, a/bb/b sit below c
    localparam half_period_t HALF_PERIOD [NOTE_COUNT] = '{
        20'd95556,   // c
        20'd90192,   // db
        20'd85131,   // d
        20'd80353,   // eb
        20'd75843,   // e
        20'd71586,   // f
        20'd67568,   // gb
        20'd63776,   // g
        20'd60196,   // ab
        20'd113636,  // a
        20'd107259,  // bb
        20'd101239   // b
    };

endpackage

// ==== hdl/display_pkg.sv ====
package display_pkg;

    // Active low, decimal point in bit 7
    typedef logic [7:0] segments_t;
    typedef logic [7:0] anodes_t;
    typedef logic [2:0] scan_slot_t;

    localparam int SCAN_SLOTS = 8;

    //////////////////////////////
    // Glyphs
    //////////////////////////////

    localparam segments_t GLYPH_A = 8'b10001000;
    localparam segments_t GLYPH_B = 8'b10000011;  // Lower case b
    localparam segments_t GLYPH_C = 8'b11000110;
    localparam segments_t GLYPH_D = 8'b10100001;  // Lower case d
    localparam segments_t GLYPH_E = 8'b10000110;
    localparam segments_t GLYPH_F = 8'b10001110;
    localparam segments_t GLYPH_G = 8'b10000010;
    localparam segments_t GLYPH_U = 8'b11000001;

    localparam segments_t BLANK = 8'b11111111;
    localparam segments_t DASH  = 8'b10111111;
    localparam segments_t QMARK = 8'b10111001;

    // Digit enable per scan slot
    localparam anodes_t SLOT_ANODES [SCAN_SLOTS] = '{
        8'b11111101,  // Note letter
        8'b11111110,  // Flat mark
        8'b01111111,  // Mode letter
        8'b10111111,
        8'b11011111,
        8'b11101111,
        8'b11111111,  // Idle
        8'b11111111
    };

endpackage

// ==== hdl/tuner_select.sv ====
`timescale 1ns/1ps

module tuner_select
    import tuner_pkg::*;
(
    input  logic  slowClk,
    input  logic  reset,
    input  logic  up,
    input  logic  down,
    input  logic  right,
    input  logic  left,
    output note_t note,
    output mode_t mode
);

    logic [3:0] btn_sync;
    logic [3:0] btn_prev;
    logic       rise_up;
    logic       rise_down;
    logic       rise_right;
    logic       rise_left;
    note_t      note_next;
    mode_t      mode_next;

    //////////////////////////////
    // String tables
    //////////////////////////////

    function automatic logic on_string(mode_t m, note_t n);
        logic hit;
        case (m)
            mode_guitar: hit = (n inside {note_e, note_a, note_d, note_g, note_b});
            mode_bass:   hit = (n inside {note_e, note_a, note_d, note_g});
            mode_uke:    hit = (n inside {note_g, note_c, note_e, note_a});
            default:     hit = 1'b1;
        endcase
        return hit;
    endfunction

    function automatic note_t first_string(mode_t m);
        return (m == mode_uke) ? note_g : note_e;
    endfunction

    // Next open string, fwd for right and back for left
    function automatic note_t step_string(mode_t m, note_t n, logic fwd);
        note_t nxt;
        case (m)
            mode_guitar:
                case (n)
                    note_e:  nxt = fwd ? note_a : note_b;
                    note_a:  nxt = fwd ? note_d : note_e;
                    note_d:  nxt = fwd ? note_g : note_a;
                    note_g:  nxt = fwd ? note_b : note_d;
                    note_b:  nxt = fwd ? note_e : note_g;
                    default: nxt = note_e;
                endcase
            mode_bass:
                case (n)
                    note_e:  nxt = fwd ? note_a : note_g;
                    note_a:  nxt = fwd ? note_d : note_e;
                    note_d:  nxt = fwd ? note_g : note_a;
                    note_g:  nxt = fwd ? note_e : note_d;
                    default: nxt = note_e;
                endcase
            mode_uke:
                case (n)
                    note_g:  nxt = fwd ? note_c : note_a;
                    note_c:  nxt = fwd ? note_e : note_g;
                    note_e:  nxt = fwd ? note_a : note_c;
                    note_a:  nxt = fwd ? note_g : note_e;
                    default: nxt = note_g;
                endcase
            default: nxt = n;
        endcase
        return nxt;
    endfunction

    //////////////////////////////
    // Button edges
    //////////////////////////////

    always_ff @(posedge slowClk or posedge reset)
    begin
        if (reset)
        begin
            btn_sync <= '0;
            btn_prev <= '0;
        end
        else
        begin
            btn_sync <= {up, down, right, left};
            btn_prev <= btn_sync;
        end
    end

    assign {rise_up, rise_down, rise_right, rise_left} = btn_sync & ~btn_prev;

    //////////////////////////////
    // Mode and note FSMs
    //////////////////////////////

    always_comb
    begin
        mode_next = mode;
        if (rise_down)
            mode_next = mode_t'(mode + 2'd1);  // custom, guitar, bass, uke
        else if (rise_up)
            mode_next = mode_t'(mode - 2'd1);
    end

    always_comb
    begin
        note_next = note;
        if (mode == mode_custom)
        begin
            if (rise_left)
                note_next = (note == note_c) ? note_b : note_t'(note - 4'd1);
            else if (rise_right)
                note_next = (note == note_b) ? note_c : note_t'(note + 4'd1);
        end
        else if (!on_string(mode, note))
            note_next = first_string(mode);  // Snap, press or not
        else if (rise_right)
            note_next = step_string(mode, note, 1'b1);
        else if (rise_left)
            note_next = step_string(mode, note, 1'b0);
    end

    always_ff @(posedge slowClk or posedge reset)
    begin
        if (reset)
        begin
            mode <= mode_custom;
            note <= note_c;
        end
        else
        begin
            mode <= mode_next;
            note <= note_next;
        end
    end

    // Settles onto a string within a cycle when idle
    assert property (@(posedge slowClk) disable iff (reset)
        (mode != mode_custom && !(rise_up || rise_down || rise_right || rise_left))
        |=> on_string(mode, note));

endmodule

// ==== hdl/tone_gen.sv ====
`timescale 1ns/1ps

module tone_gen
    import tuner_pkg::*;
#(
    parameter int PITCH_SHIFT = 0
)
(
    input  logic  slowClk,
    input  logic  reset,
    input  logic  play,
    input  note_t note,
    output logic  audio
);

    half_period_t half;
    half_period_t count;
    note_t        note_q;

    assign half = HALF_PERIOD[note] >> PITCH_SHIFT;

    //////////////////////////////
    // Square wave
    //////////////////////////////

    always_ff @(posedge slowClk or posedge reset)
    begin
        if (reset)
        begin
            count  <= '0;
            audio  <= 1'b1;
            note_q <= note_c;
        end
        else
        begin
            note_q <= note;
            if (!play)
            begin
                count <= '0;
                audio <= 1'b1;  // Idle level
            end
            else if (note != note_q)
                count <= '0;    // New pitch, start a fresh half period
            else if (count >= half - 20'd1)
            begin
                count <= '0;
                audio <= ~audio;
            end
            else
                count <= count + 20'd1;
        end
    end

    assert property (@(posedge slowClk) disable iff (reset)
        !$past(play) |-> audio);

endmodule

// ==== hdl/seg_scan.sv ====
`timescale 1ns/1ps

module seg_scan
    import tuner_pkg::*;
    import display_pkg::*;
#(
    parameter int SCAN_DIV = 12500
)
(
    input  logic      slowClk,
    input  logic      reset,
    input  note_t     note,
    input  mode_t     mode,
    output segments_t seg,
    output anodes_t   an
);

    localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    scan_slot_t       slot;
    segments_t        letter_seg;
    segments_t        flat_seg;
    segments_t        mode_seg;

    //////////////////////////////
    // Scan timing
    //////////////////////////////

    always_ff @(posedge slowClk or posedge reset)
    begin
        if (reset)
        begin
            div_cnt <= '0;
            slot    <= '0;
        end
        else if (div_cnt == DIV_W'(SCAN_DIV - 1))
        begin
            div_cnt <= '0;
            slot    <= slot + 3'd1;  // Wraps after 7
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    //////////////////////////////
    // Glyphs
    //////////////////////////////

    always_comb
    begin
        case (note)
            note_c:          letter_seg = GLYPH_C;
            note_db, note_d: letter_seg = GLYPH_D;
            note_eb, note_e: letter_seg = GLYPH_E;
            note_f:          letter_seg = GLYPH_F;
            note_gb, note_g: letter_seg = GLYPH_G;
            note_ab, note_a: letter_seg = GLYPH_A;
            note_bb, note_b: letter_seg = GLYPH_B;
            default:         letter_seg = BLANK;
        endcase
    end

    // Flat mark shares the b pattern
    assign flat_seg = (note inside {note_db, note_eb, note_gb, note_ab, note_bb}) ?
                      GLYPH_B : BLANK;

    always_comb
    begin
        case (mode)
            mode_custom: mode_seg = GLYPH_C;
            mode_guitar: mode_seg = GLYPH_G;
            mode_bass:   mode_seg = GLYPH_B;
            default:     mode_seg = GLYPH_U;
        endcase
    end

    assign an = SLOT_ANODES[slot];

    always_comb
    begin
        case (slot)
            3'd0:    seg = letter_seg;
            3'd1:    seg = flat_seg;
            3'd2:    seg = mode_seg;
            3'd3,
            3'd4:    seg = DASH;
            3'd5:    seg = QMARK;
            default: seg = BLANK;  // Dark slots
        endcase
    end

    assert property (@(posedge slowClk) disable iff (reset)
        $countones(~an) <= 1);

endmodule

// ==== hdl/string_tuner.sv ====
`timescale 1ns/1ps

module string_tuner
    import tuner_pkg::*;
    import display_pkg::*;
#(
    parameter int PITCH_SHIFT = 0,
    parameter int SCAN_DIV    = 12500
)
(
    input  logic      slowClk,
    input  logic      reset,
    input  logic      up,
    input  logic      down,
    input  logic      right,
    input  logic      left,
    input  logic      play,
    output logic      audio,
    output logic      audio_en,
    output segments_t seg,
    output anodes_t   an
);

    note_t note;
    mode_t mode;

    tuner_select u_tuner_select (
        .slowClk (slowClk),
        .reset   (reset),
        .up      (up),
        .down    (down),
        .right   (right),
        .left    (left),
        .note    (note),
        .mode    (mode)
    );

    tone_gen #(
        .PITCH_SHIFT (PITCH_SHIFT)
    ) u_tone_gen (
        .slowClk (slowClk),
        .reset   (reset),
        .play    (play),
        .note    (note),
        .audio   (audio)
    );

    assign audio_en = 1'b1;  // Amplifier always on

    seg_scan #(
        .SCAN_DIV (SCAN_DIV)
    ) u_seg_scan (
        .slowClk (slowClk),
        .reset   (reset),
        .note    (note),
        .mode    (mode),
        .seg     (seg),
        .an      (an)
    );

endmodule

// ==== testbench/tb_string_tuner.sv ====
`timescale 1ns/1ps

module tb_string_tuner
    import tuner_pkg::*;
    import display_pkg::*;
();

    localparam int PITCH_SHIFT = 10;
    localparam int SCAN_DIV    = 4;

    localparam segments_t FLAT_SEG  = 8'h83;
    localparam segments_t BLANK_SEG = 8'hff;
    localparam segments_t DASH_SEG  = 8'hbf;
    localparam segments_t QMARK_SEG = 8'hb9;

    logic      slowClk = 1'b0;
    logic      reset, up, down, right, left, play;
    logic      audio, audio_en;
    segments_t seg;
    anodes_t   an;

    // One entry per test line
    logic [63:0]  btn_q[$];
    logic         play_q[$];
    segments_t    letter_q[$];
    logic         flat_q[$];
    segments_t    mode_q[$];
    half_period_t half_q[$];

    always #10 slowClk = ~slowClk;

    string_tuner #(
        .PITCH_SHIFT (PITCH_SHIFT),
        .SCAN_DIV    (SCAN_DIV)
    ) u_string_tuner (
        .slowClk  (slowClk),
        .reset    (reset),
        .up       (up),
        .down     (down),
        .right    (right),
        .left     (left),
        .play     (play),
        .audio    (audio),
        .audio_en (audio_en),
        .seg      (seg),
        .an       (an)
    );

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic report_error(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic compare_glyph(input string name, input segments_t got, input segments_t exp);
        if (got !== exp)
            report_error($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    task automatic compare_half(input string name, input half_period_t got,
                                input half_period_t exp);
        if (got !== exp)
            report_error($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    task automatic compare_level(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_error($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    task automatic watch_timeout(input int cycles);
        repeat (cycles) @(posedge slowClk);
        $display("Run timed out after %0d cycles", cycles);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    //////////////////////////////
    // Stimulus and capture
    //////////////////////////////

    // One cycle pulse, play level set with it
    task automatic press_button(input logic [63:0] name, input logic lvl);
        @(posedge slowClk);
        play <= lvl;
        case (name)
            "none": ;
            "up":    up <= 1'b1;
            "down":  down <= 1'b1;
            "right": right <= 1'b1;
            "left":  left <= 1'b1;
            "rl":
            begin
                right <= 1'b1;
                left  <= 1'b1;
            end
            "ud":
            begin
                up   <= 1'b1;
                down <= 1'b1;
            end
            default: report_error($sformatf("Unknown button %0s in test file", name));
        endcase
        @(posedge slowClk);
        {up, down, right, left} <= 4'b0000;
    endtask

    // Exactly one full scan of eight slots
    task automatic capture_scan(input logic hold_high, output segments_t letter,
                                output segments_t flat_g, output segments_t mode_g);
        logic [6:0] seen;
        seen   = '0;
        letter = BLANK_SEG;
        flat_g = BLANK_SEG;
        mode_g = BLANK_SEG;
        repeat (8 * SCAN_DIV)
        begin
            @(negedge slowClk);
            if (hold_high)
                compare_level("audio", audio, 1'b1);
            compare_level("audio_en", audio_en, 1'b1);
            case (an)
                8'b11111101: {letter, seen[0]} = {seg, 1'b1};
                8'b11111110: {flat_g, seen[1]} = {seg, 1'b1};
                8'b01111111: {mode_g, seen[2]} = {seg, 1'b1};
                8'b10111111: {seen[3]} = 1'b1;
                8'b11011111: {seen[4]} = 1'b1;
                8'b11101111: {seen[5]} = 1'b1;
                8'b11111111: {seen[6]} = 1'b1;
                default: report_error($sformatf("Several digits enabled at once, an %h", an));
            endcase
            if (an == 8'b10111111 || an == 8'b11011111)
                compare_glyph("seg dash", seg, DASH_SEG);
            else if (an == 8'b11101111)
                compare_glyph("seg qmark", seg, QMARK_SEG);
            else if (an == 8'b11111111)
                compare_glyph("seg idle", seg, BLANK_SEG);
        end
        if (seen != 7'h7f)
            report_error("Display scan did not visit every digit");
    endtask

    // Cycles between two audio edges, first edge skipped
    task automatic measure_half(output half_period_t width);
        logic last;
        @(negedge slowClk);
        last = audio;
        while (audio === last)
            @(negedge slowClk);
        last  = audio;
        width = '0;
        do
        begin
            @(negedge slowClk);
            width = width + 20'd1;
        end
        while (audio === last);
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial
    begin
        int            fd;
        int            n;
        logic [63:0]   tok;
        logic [2047:0] rest;
        logic          play_v, flat_v;
        segments_t     letter_v, mode_v, letter, flat_g, mode_g;
        half_period_t  half_v, longest, width;

        reset = 1'b1;
        {up, down, right, left, play} = 5'b00000;
        longest = '0;

        fd = $fopen("testbench/tuner_tests.txt", "r");
        if (fd == 0)
            report_error("Cannot open testbench/tuner_tests.txt");
        while (!$feof(fd))
        begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1)
                break;
            if (tok == "#")
                n = $fgets(rest, fd);  // Comment line
            else
            begin
                n = $fscanf(fd, "%d %h %d %h %h", play_v, letter_v, flat_v, mode_v, half_v);
                if (n != 5)
                    report_error("Malformed line in test file");
                btn_q.push_back(tok);
                play_q.push_back(play_v);
                letter_q.push_back(letter_v);
                flat_q.push_back(flat_v);
                mode_q.push_back(mode_v);
                half_q.push_back(half_v);
                if (half_v > longest)
                    longest = half_v;
            end
        end
        $fclose(fd);

        fork
            watch_timeout(10 + btn_q.size() * 200 + 4 * int'(longest));
        join_none

        repeat (10) @(posedge slowClk);
        reset <= 1'b0;

        foreach (btn_q[i])
        begin
            press_button(btn_q[i], play_q[i]);
            repeat (16) @(posedge slowClk);
            capture_scan(!play_q[i], letter, flat_g, mode_g);
            compare_glyph("seg note letter", letter, letter_q[i]);
            compare_glyph("seg flat mark", flat_g, flat_q[i] ? FLAT_SEG : BLANK_SEG);
            compare_glyph("seg mode letter", mode_g, mode_q[i]);
            if (play_q[i])
            begin
                measure_half(width);
                compare_half("audio half period", width, half_q[i]);
            end
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== testbench/tuner_tests.txt ====
# button play note_glyph flat mode_glyph half_period
# glyphs and half period in hex, half period is slowClk cycles and 0 when play is low
none 0 c6 0 c6 0
right 0 a1 1 c6 0
right 0 a1 0 c6 0
right 0 86 1 c6 0
right 0 86 0 c6 0
right 0 8e 0 c6 0
right 0 82 1 c6 0
right 0 82 0 c6 0
right 0 88 1 c6 0
right 0 88 0 c6 0
right 0 83 1 c6 0
right 0 83 0 c6 0
right 0 c6 0 c6 0
left 0 83 0 c6 0
rl 0 83 1 c6 0
down 0 86 0 82 0
right 0 88 0 82 0
right 0 a1 0 82 0
right 0 82 0 82 0
right 0 83 0 82 0
right 0 86 0 82 0
left 0 83 0 82 0
down 0 86 0 83 0
left 0 82 0 83 0
rl 0 86 0 83 0
right 0 88 0 83 0
right 0 a1 0 83 0
down 1 82 0 c1 3e
right 1 c6 0 c1 5d
right 1 86 0 c1 4a
right 1 88 0 c1 6e
right 1 82 0 c1 3e
ud 1 82 0 c6 3e
up 1 82 0 c1 3e
up 0 82 0 83 0
up 0 82 0 82 0
up 0 82 0 c6 0

// ==== string_tuner.f ====
hdl/tuner_pkg.sv
hdl/display_pkg.sv
hdl/tuner_select.sv
hdl/tone_gen.sv
hdl/seg_scan.sv
hdl/string_tuner.sv
testbench/tb_string_tuner.sv

// ==== Bender.yml ====
package:
  name: string_tuner

sources:
  - hdl/tuner_pkg.sv
  - hdl/display_pkg.sv
  - hdl/tuner_select.sv
  - hdl/tone_gen.sv
  - hdl/seg_scan.sv
  - hdl/string_tuner.sv
  - target: test
    files:
      - testbench/tb_string_tuner.sv
